/* common/adam_defs.svh */
`ifndef ADAM_DEFS_SVH
`define ADAM_DEFS_SVH

// request and data widths
`define ADAM_ADDR_W 8
`define ADAM_DATA_W 32

// word memory geometry
`define ADAM_MEM_DEPTH 64
`define ADAM_MEM_AW 6

// cycles between request acceptance and memory strobe
`define ADAM_MEM_WAIT 3

// register space, selected by address bit 7
`define ADAM_REG_CTRL 8'h80
`define ADAM_REG_STATUS 8'h81
`define ADAM_REG_ID 8'h82

`define ADAM_ID_VALUE 32'hADA0_0001

`endif

/* common/adam_mem_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adam_defs.svh"

interface adam_mem_if
    import adam_pkg::*;
();

    logic                    mem_en;
    op_e                     mem_op;
    logic [`ADAM_MEM_AW-1:0] mem_addr;
    logic [`ADAM_DATA_W-1:0] mem_wdata;
    // valid one cycle after mem_en
    logic [`ADAM_DATA_W-1:0] mem_rdata;

    modport brg (
        output mem_en, mem_op, mem_addr, mem_wdata,
        input  mem_rdata
    );

    modport ram (
        input  mem_en, mem_op, mem_addr, mem_wdata,
        output mem_rdata
    );

endinterface

`default_nettype wire

/* common/adam_pkg.sv */
`default_nettype none

package adam_pkg;

    // pause handshake of the memory unit
    typedef enum logic [1:0] {
        RUN    = 2'd0,
        DRAIN  = 2'd1,
        PAUSED = 2'd2
    } pause_state_e;

    // memory access kind
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

endpackage

`default_nettype wire

/* common/adam_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adam_defs.svh"

interface adam_req_if
    import adam_pkg::*;
();

    // forwarded memory request
    logic                    fwd_valid;
    op_e                     fwd_op;
    logic [`ADAM_MEM_AW-1:0] fwd_addr;
    logic [`ADAM_DATA_W-1:0] fwd_wdata;

    // response back from the bridge
    logic                    rsp_valid;
    logic [`ADAM_DATA_W-1:0] rsp_rdata;
    logic                    rsp_err;
    logic                    busy;

    modport cfg (
        output fwd_valid, fwd_op, fwd_addr, fwd_wdata,
        input  rsp_valid, rsp_rdata, rsp_err
    );

    modport brg (
        input  fwd_valid, fwd_op, fwd_addr, fwd_wdata,
        output rsp_valid, rsp_rdata, rsp_err, busy
    );

endinterface

`default_nettype wire

/* design/adam_lite.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adam_defs.svh"

module adam_lite (
    input  logic                    clk_i,
    input  logic                    arst_n_i,

    input  logic                    req_i,
    input  logic                    req_we_i,
    input  logic [`ADAM_ADDR_W-1:0] req_addr_i,
    input  logic [`ADAM_DATA_W-1:0] req_wdata_i,

    output logic                    rsp_valid_o,
    output logic [`ADAM_DATA_W-1:0] rsp_rdata_o,
    output logic                    rsp_err_o
);

    adam_req_if req_bus ();
    adam_mem_if mem_bus ();

    logic mem_rst;
    logic pause_req;
    logic paused;

    adam_syscfg u_syscfg (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_i       (req_i),
        .req_we_i    (req_we_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_rdata_o (rsp_rdata_o),
        .rsp_err_o   (rsp_err_o),
        .req         (req_bus),
        .paused_i    (paused),
        .mem_rst_o   (mem_rst),
        .pause_req_o (pause_req)
    );

    adam_pause_fsm u_pause_fsm (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .pause_req_i (pause_req),
        .mem_rst_i   (mem_rst),
        .busy_i      (req_bus.busy),
        .paused_o    (paused)
    );

    adam_mem_bridge u_mem_bridge (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .paused_i  (paused),
        .mem_rst_i (mem_rst),
        .req       (req_bus),
        .mem       (mem_bus)
    );

    adam_mem u_mem (
        .clk_i (clk_i),
        .mem   (mem_bus)
    );

endmodule

`default_nettype wire

/* mem/adam_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adam_defs.svh"

module adam_mem
    import adam_pkg::*;
(
    input  logic    clk_i,
    adam_mem_if.ram mem
);

    logic [`ADAM_DATA_W-1:0] words_q [`ADAM_MEM_DEPTH];
    logic [`ADAM_DATA_W-1:0] rdata_q;

    // single port, read and write share the strobe
    always_ff @(posedge clk_i) begin
        if (mem.mem_en) begin
            if (mem.mem_op == OP_WRITE) begin
                words_q[mem.mem_addr] <= mem.mem_wdata;
            end else begin
                rdata_q <= words_q[mem.mem_addr];
            end
        end
    end

    assign mem.mem_rdata = rdata_q;

endmodule

`default_nettype wire

/* mem/adam_mem_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adam_defs.svh"

module adam_mem_bridge
    import adam_pkg::*;
(
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  logic    paused_i,
    input  logic    mem_rst_i,
    adam_req_if.brg req,
    adam_mem_if.brg mem
);

    logic                    accept;
    logic                    refuse;
    logic                    timer_done;
    logic                    busy_q;
    logic                    done_q;
    logic                    refuse_q;
    op_e                     op_q;
    logic [`ADAM_MEM_AW-1:0] addr_q;
    logic [`ADAM_DATA_W-1:0] wdata_q;

    assign refuse = req.fwd_valid && (paused_i || mem_rst_i);
    assign accept = req.fwd_valid && !paused_i && !mem_rst_i;

    adam_wait_timer u_wait_timer (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .load_i   (accept),
        .clear_i  (mem_rst_i),
        .done_o   (timer_done)
    );

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            refuse_q <= 1'b0;
        end else begin
            refuse_q <= refuse;
            if (mem_rst_i) begin
                // drop the access in flight, no response
                busy_q <= 1'b0;
                done_q <= 1'b0;
            end else begin
                done_q <= timer_done;
                if (accept) busy_q <= 1'b1;
                else if (timer_done) busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q    <= req.fwd_op;
            addr_q  <= req.fwd_addr;
            wdata_q <= req.fwd_wdata;
        end
    end

    assign mem.mem_en    = timer_done && !mem_rst_i;
    assign mem.mem_op    = op_q;
    assign mem.mem_addr  = addr_q;
    assign mem.mem_wdata = wdata_q;

    // accept cycle counts as in flight for the pause drain
    assign req.busy      = busy_q || accept;
    assign req.rsp_valid = done_q || refuse_q;
    assign req.rsp_err   = refuse_q;
    assign req.rsp_rdata = (done_q && op_q == OP_READ) ? mem.mem_rdata : '0;

endmodule

`default_nettype wire

/* mem/adam_wait_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adam_defs.svh"

module adam_wait_timer (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic load_i,
    input  logic clear_i,
    output logic done_o
);

    localparam int unsigned CNT_W = $clog2(`ADAM_MEM_WAIT + 1);

    logic             active_q;
    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
        end else if (clear_i) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
        end else if (load_i) begin
            active_q <= 1'b1;
            cnt_q    <= CNT_W'(`ADAM_MEM_WAIT);
        end else if (active_q) begin
            if (cnt_q == '0) active_q <= 1'b0;
            else cnt_q <= cnt_q - 1'b1;
        end
    end

    assign done_o = active_q && (cnt_q == '0);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_adam_lite -f tb.f -o tb_adam_lite \
    && ./obj_dir/tb_adam_lite +verilator+error+limit+1000 | tee /dev/stderr | grep -q "TEST OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* syscfg/adam_pause_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module adam_pause_fsm
    import adam_pkg::*;
(
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic pause_req_i,
    input  logic mem_rst_i,
    input  logic busy_i,
    output logic paused_o
);

    pause_state_e state_q;
    pause_state_e state_d;

    always_comb begin
        state_d = state_q;
        if (mem_rst_i) begin
            // unit held in reset is never reported paused
            state_d = RUN;
        end else begin
            case (state_q)
                RUN: begin
                    if (pause_req_i) state_d = DRAIN;
                end
                DRAIN: begin
                    if (!pause_req_i) state_d = RUN;
                    else if (!busy_i) state_d = PAUSED;
                end
                PAUSED: begin
                    if (!pause_req_i) state_d = RUN;
                end
                default: state_d = RUN;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= RUN;
        end else begin
            state_q <= state_d;
        end
    end

    assign paused_o = (state_q == PAUSED);

endmodule

`default_nettype wire

/* syscfg/adam_syscfg.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adam_defs.svh"

module adam_syscfg
    import adam_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    arst_n_i,

    input  logic                    req_i,
    input  logic                    req_we_i,
    input  logic [`ADAM_ADDR_W-1:0] req_addr_i,
    input  logic [`ADAM_DATA_W-1:0] req_wdata_i,

    output logic                    rsp_valid_o,
    output logic [`ADAM_DATA_W-1:0] rsp_rdata_o,
    output logic                    rsp_err_o,

    adam_req_if.cfg                 req,

    input  logic                    paused_i,
    output logic                    mem_rst_o,
    output logic                    pause_req_o
);

    logic                    mem_hit;
    logic                    loc_hit;
    logic                    loc_err;
    logic [`ADAM_DATA_W-1:0] loc_rdata;
    logic [1:0]              ctrl_q;
    logic                    loc_valid_q;
    logic                    loc_err_q;
    logic [`ADAM_DATA_W-1:0] loc_rdata_q;

    // bit 7 clear and below the memory depth
    assign mem_hit = !req_addr_i[`ADAM_ADDR_W-1]
                  && (req_addr_i[`ADAM_ADDR_W-2:`ADAM_MEM_AW] == '0);
    assign loc_hit = req_i && !mem_hit;

    assign req.fwd_valid = req_i && mem_hit;
    assign req.fwd_op    = req_we_i ? OP_WRITE : OP_READ;
    assign req.fwd_addr  = req_addr_i[`ADAM_MEM_AW-1:0];
    assign req.fwd_wdata = req_wdata_i;

    always_comb begin
        loc_err   = 1'b0;
        loc_rdata = '0;
        if (!req_addr_i[`ADAM_ADDR_W-1]) begin
            // unmapped gap above the memory
            loc_err = 1'b1;
        end else begin
            case (req_addr_i)
                `ADAM_REG_CTRL: begin
                    if (!req_we_i) loc_rdata = {{(`ADAM_DATA_W-2){1'b0}}, ctrl_q};
                end
                `ADAM_REG_STATUS: begin
                    if (req_we_i) loc_err = 1'b1;
                    else loc_rdata = {{(`ADAM_DATA_W-1){1'b0}}, paused_i};
                end
                `ADAM_REG_ID: begin
                    if (req_we_i) loc_err = 1'b1;
                    else loc_rdata = `ADAM_ID_VALUE;
                end
                default: loc_err = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q      <= '0;
            loc_valid_q <= 1'b0;
            loc_err_q   <= 1'b0;
        end else begin
            loc_valid_q <= loc_hit;
            loc_err_q   <= loc_hit && loc_err;
            if (req_i && req_we_i && req_addr_i == `ADAM_REG_CTRL) begin
                ctrl_q <= req_wdata_i[1:0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (loc_hit) loc_rdata_q <= loc_rdata;
    end

    assign mem_rst_o   = ctrl_q[0];
    assign pause_req_o = ctrl_q[1];

    // local and bridge responses never overlap
    assign rsp_valid_o = loc_valid_q || req.rsp_valid;
    assign rsp_rdata_o = loc_valid_q ? loc_rdata_q : req.rsp_rdata;
    assign rsp_err_o   = loc_valid_q ? loc_err_q : req.rsp_err;

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
common/adam_pkg.sv
common/adam_req_if.sv
common/adam_mem_if.sv
mem/adam_wait_timer.sv
mem/adam_mem.sv
mem/adam_mem_bridge.sv
syscfg/adam_pause_fsm.sv
syscfg/adam_syscfg.sv
design/adam_lite.sv
verif/adam_lite_props.sv
verif/tb_adam_lite.sv

/* verif/adam_lite_props.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adam_defs.svh"

module adam_lite_props (
    input logic                    clk_i,
    input logic                    arst_n_i,
    input logic                    req_i,
    input logic [`ADAM_ADDR_W-1:0] req_addr_i,
    input logic                    rsp_valid_o,
    input logic                    rsp_err_o,
    input logic                    paused_i,
    input logic                    mem_rst_i
);

    logic mem_hit;
    logic fast_rsp;
    logic pending_q;
    int   fail_cnt = 0;

    assign mem_hit  = req_addr_i < `ADAM_ADDR_W'(`ADAM_MEM_DEPTH);
    // answered by the register block or refused by the bridge
    assign fast_rsp = !mem_hit || paused_i || mem_rst_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= 1'b0;
        end else if (req_i) begin
            pending_q <= 1'b1;
        end else if (rsp_valid_o) begin
            pending_q <= 1'b0;
        end
    end

    local_rsp_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req_i && fast_rsp |=> rsp_valid_o)
        else begin
            $error("register or refused request missed its 1-cycle response");
            fail_cnt++;
        end

    mem_latency_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req_i && !fast_rsp |-> ##(`ADAM_MEM_WAIT+2) (rsp_valid_o && !rsp_err_o))
        else begin
            $error("accepted memory access missed its response cycle");
            fail_cnt++;
        end

    orphan_rsp_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rsp_valid_o |-> pending_q)
        else begin
            $error("response without an outstanding request");
            fail_cnt++;
        end

    overlap_req_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req_i |-> !pending_q)
        else begin
            $error("new request while one is outstanding");
            fail_cnt++;
        end

    err_valid_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rsp_err_o |-> rsp_valid_o)
        else begin
            $error("error flag without a response");
            fail_cnt++;
        end

endmodule

bind adam_lite adam_lite_props u_props (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (req_i),
    .req_addr_i  (req_addr_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_err_o   (rsp_err_o),
    .paused_i    (paused),
    .mem_rst_i   (mem_rst)
);

`default_nettype wire

/* verif/tb_adam_lite.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adam_defs.svh"

module tb_adam_lite;

    localparam int MAX_CYCLES = 3000;

    logic                    clk_i;
    logic                    arst_n_i;
    logic                    req_i;
    logic                    req_we_i;
    logic [`ADAM_ADDR_W-1:0] req_addr_i;
    logic [`ADAM_DATA_W-1:0] req_wdata_i;
    logic                    rsp_valid_o;
    logic [`ADAM_DATA_W-1:0] rsp_rdata_o;
    logic                    rsp_err_o;

    // reference copy of the word memory
    logic [`ADAM_DATA_W-1:0] model_mem [`ADAM_MEM_DEPTH];
    logic [`ADAM_ADDR_W-1:0] used_addr [16];
    int                      check_errs = 0;
    int                      tests_passed = 0;
    int                      tests_failed = 0;
    int                      cycle_cnt = 0;

    adam_lite DUT (.*);

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic int total_errors();
        return check_errs + DUT.u_props.fail_cnt;
    endfunction

    task automatic idle(input int n);
        repeat (n) @(posedge clk_i);
    endtask

    task automatic expect_no_rsp(input int n);
        repeat (n) begin
            @(negedge clk_i);
            assert (rsp_valid_o == 1'b0) else begin
                $display("** Error: rsp_valid_o expected 0x0 actual 0x%h", rsp_valid_o);
                check_errs++;
            end
        end
    endtask

    // one request, then wait for its response
    task automatic send_req(input logic we, input logic [`ADAM_ADDR_W-1:0] addr,
                            input logic [`ADAM_DATA_W-1:0] wdata, input logic exp_err,
                            input logic [`ADAM_DATA_W-1:0] exp_rdata);
        int wait_cnt;
        wait_cnt = 0;
        @(posedge clk_i);
        #1;
        req_i       = 1'b1;
        req_we_i    = we;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        @(posedge clk_i);
        #1;
        req_i = 1'b0;
        @(negedge clk_i);
        while (!rsp_valid_o && wait_cnt < 20) begin
            @(negedge clk_i);
            wait_cnt++;
        end
        if (!rsp_valid_o) begin
            $display("no response to the request at address 0x%h", addr);
            check_errs++;
        end else begin
            assert (rsp_err_o == exp_err) else begin
                $display("** Error: rsp_err_o at 0x%h expected 0x%h actual 0x%h",
                         addr, exp_err, rsp_err_o);
                check_errs++;
            end
            if (!exp_err) begin
                assert (rsp_rdata_o == exp_rdata) else begin
                    $display("** Error: rsp_rdata_o at 0x%h expected 0x%h actual 0x%h",
                             addr, exp_rdata, rsp_rdata_o);
                    check_errs++;
                end
            end
        end
    endtask

    task automatic write_word(input logic [`ADAM_ADDR_W-1:0] addr,
                              input logic [`ADAM_DATA_W-1:0] data);
        model_mem[addr[`ADAM_MEM_AW-1:0]] = data;
        send_req(1'b1, addr, data, 1'b0, '0);
    endtask

    task automatic check_words();
        for (int i = 0; i < 16; i++) begin
            send_req(1'b0, used_addr[i], '0, 1'b0, model_mem[used_addr[i][`ADAM_MEM_AW-1:0]]);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        // let pending assertions mature
        idle(2);
        if (total_errors() == errs_before) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed", name);
        end
    endtask

    initial begin
        int                      errs;
        logic [31:0]             rnd;
        logic [`ADAM_ADDR_W-1:0] addr;
        clk_i       = 1'b0;
        arst_n_i    = 1'b0;
        req_i       = 1'b0;
        req_we_i    = 1'b0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        void'($urandom(103));

        errs = total_errors();
        expect_no_rsp(8);
        @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        expect_no_rsp(3);
        send_req(1'b0, `ADAM_REG_CTRL, '0, 1'b0, '0);
        send_req(1'b0, `ADAM_REG_STATUS, '0, 1'b0, '0);
        send_req(1'b0, `ADAM_REG_ID, '0, 1'b0, `ADAM_ID_VALUE);
        report_test("reset state", errs);

        errs = total_errors();
        for (int i = 0; i < 16; i++) begin
            rnd = $urandom;
            used_addr[i] = {2'b00, rnd[5:0]};
            write_word(used_addr[i], $urandom);
        end
        check_words();
        report_test("memory access", errs);

        errs = total_errors();
        for (int i = 0; i < 8; i++) begin
            rnd = $urandom;
            // gap address whose low bits alias a written word
            addr = {2'b01, used_addr[i][5:0]};
            send_req(1'b1, addr, $urandom, 1'b1, '0);
            send_req(1'b0, addr, '0, 1'b1, '0);
            addr = 8'h83 + 8'(rnd[15:8] % 125);
            send_req(1'b1, addr, $urandom, 1'b1, '0);
            send_req(1'b0, addr, '0, 1'b1, '0);
        end
        send_req(1'b1, `ADAM_REG_STATUS, 32'h3, 1'b1, '0);
        send_req(1'b1, `ADAM_REG_ID, $urandom, 1'b1, '0);
        send_req(1'b0, `ADAM_REG_CTRL, '0, 1'b0, '0);
        send_req(1'b0, `ADAM_REG_STATUS, '0, 1'b0, '0);
        send_req(1'b0, `ADAM_REG_ID, '0, 1'b0, `ADAM_ID_VALUE);
        check_words();
        report_test("decode errors", errs);

        errs = total_errors();
        send_req(1'b1, `ADAM_REG_CTRL, 32'h2, 1'b0, '0);
        // FSM needs a few edges to reach PAUSED
        idle(3);
        send_req(1'b0, `ADAM_REG_STATUS, '0, 1'b0, 32'h1);
        send_req(1'b0, `ADAM_REG_CTRL, '0, 1'b0, 32'h2);
        send_req(1'b1, used_addr[0], $urandom, 1'b1, '0);
        send_req(1'b0, used_addr[0], '0, 1'b1, '0);
        send_req(1'b1, `ADAM_REG_CTRL, 32'h0, 1'b0, '0);
        idle(3);
        send_req(1'b0, `ADAM_REG_STATUS, '0, 1'b0, '0);
        check_words();
        report_test("pause", errs);

        errs = total_errors();
        send_req(1'b1, `ADAM_REG_CTRL, 32'h3, 1'b0, '0);
        idle(3);
        send_req(1'b0, `ADAM_REG_STATUS, '0, 1'b0, '0);
        send_req(1'b0, `ADAM_REG_CTRL, '0, 1'b0, 32'h3);
        send_req(1'b1, used_addr[1], $urandom, 1'b1, '0);
        send_req(1'b0, used_addr[1], '0, 1'b1, '0);
        send_req(1'b1, `ADAM_REG_CTRL, 32'h0, 1'b0, '0);
        idle(3);
        check_words();
        report_test("soft reset", errs);

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_passed, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
